//--- rf_pg_ctrl.f
+incdir+verification
verilog/rf_geom_pkg.sv
verilog/rf_cmd_pkg.sv
verilog/rf_array_model.sv
verilog/rf_pg_256x25.sv
verilog/rf_cmd_decode.sv
verilog/rf_cmd_execute.sv
verilog/rf_rsp_result.sv
verilog/rf_pg_ctrl_top.sv
verification/rf_pg_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# The run passes only if the testbench prints its pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
        --top-module rf_pg_ctrl_tb -f rf_pg_ctrl.f \
    && ./obj_dir/Vrf_pg_ctrl_tb | tee /dev/stderr | grep -q '^Done: no errors$' \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- verification/rf_pg_ctrl_check.svh
// --------------------
// Reference model and compare tasks for the controller testbench
// Shadow memory and power state, expected responses and typed checks
// --------------------

`ifndef RF_PG_CTRL_CHECK_SVH
`define RF_PG_CTRL_CHECK_SVH

// Shadow of the array, an entry is known once written since the last power-down
rf_geom_pkg::rf_word_t shadow_mem   [rf_geom_pkg::RF_DEPTH];
bit                    shadow_known [rf_geom_pkg::RF_DEPTH];
bit                    shadow_asleep;

// Expected response of one command, applied in acceptance order
// cmp_data is cleared when the read hits an entry with unknown contents
function automatic rf_cmd_pkg::rf_rsp_t ref_response(input rf_cmd_pkg::rf_cmd_t c,
                                                     output bit cmp_data);
    rf_cmd_pkg::rf_rsp_t r;
    r.op     = c.op;
    r.status = rf_cmd_pkg::ST_OK;
    r.rdata  = '0;
    cmp_data = 1'b1;
    case (c.op)
        rf_cmd_pkg::OP_WRITE: begin
            if (shadow_asleep) begin
                r.status = rf_cmd_pkg::ST_ASLEEP;
            end else begin
                shadow_mem[c.addr]   = c.operand.data;
                shadow_known[c.addr] = 1'b1;
            end
        end
        rf_cmd_pkg::OP_READ: begin
            if (shadow_asleep) begin
                r.status = rf_cmd_pkg::ST_ASLEEP;
            end else if (shadow_known[c.addr]) begin
                r.rdata = shadow_mem[c.addr];
            end else begin
                cmp_data = 1'b0;
            end
        end
        rf_cmd_pkg::OP_SLEEP: begin
            if (shadow_asleep) begin
                r.status = rf_cmd_pkg::ST_BAD_STATE;
            end else begin
                // Power-down wipes every entry
                shadow_asleep = 1'b1;
                for (int i = 0; i < rf_geom_pkg::RF_DEPTH; i++) begin
                    shadow_known[i] = 1'b0;
                end
            end
        end
        rf_cmd_pkg::OP_WAKE: begin
            if (!shadow_asleep) begin
                r.status = rf_cmd_pkg::ST_BAD_STATE;
            end else begin
                shadow_asleep = 1'b0;
            end
        end
        default: begin
            r.status = rf_cmd_pkg::ST_BAD_OP;
        end
    endcase
    return r;
endfunction

// --------------------
// Typed compares, one per response field

task automatic check_status(input rf_cmd_pkg::rf_status_e got,
                            input rf_cmd_pkg::rf_status_e exp);
    if (got !== exp) begin
        $display("Fail rsp.status: got %h, expected %h", got, exp);
        err_count++;
    end
endtask

task automatic check_op(input rf_cmd_pkg::rf_op_e got, input rf_cmd_pkg::rf_op_e exp);
    if (got !== exp) begin
        $display("Fail rsp.op: got %h, expected %h", got, exp);
        err_count++;
    end
endtask

task automatic check_rdata(input rf_geom_pkg::rf_word_t got, input rf_geom_pkg::rf_word_t exp);
    if (got !== exp) begin
        $display("Fail rsp.rdata: got %h, expected %h", got, exp);
        err_count++;
    end
endtask

`endif

//--- verification/rf_pg_ctrl_tb.sv
// --------------------
// Testbench for the power-gated register file controller
// Drives commands, stalls responses and checks them against a reference model
// --------------------

`timescale 1ns/100ps

module rf_pg_ctrl_tb;

// Command counts of the five tests, they also set the cycle limit
localparam int N_TOTAL     = 32 + 48 + 10 + 18 + 10;
localparam int CYCLE_LIMIT = 40 * N_TOTAL + 8;

logic                clk;
logic                arst_n;
logic                cmd_valid;
logic                cmd_ready;
rf_cmd_pkg::rf_cmd_t cmd;
logic                rsp_valid;
logic                rsp_ready;
rf_cmd_pkg::rf_rsp_t rsp;

int  err_count = 0;
int  rsp_count = 0;
int  cmd_count = 0;
int  cycles    = 0;
int  test_err0;
int  test_cmd0;
bit  stall_en;

// Expected responses in command order, with a flag for comparing read data
rf_cmd_pkg::rf_rsp_t exp_q [$];
bit                  cmp_q [$];

`include "rf_pg_ctrl_check.svh"

rf_pg_ctrl_top uut (
     .clk       (clk)
    ,.arst_n    (arst_n)
    ,.cmd_valid (cmd_valid)
    ,.cmd_ready (cmd_ready)
    ,.cmd       (cmd)
    ,.rsp_valid (rsp_valid)
    ,.rsp_ready (rsp_ready)
    ,.rsp       (rsp)
);

always #10 clk = ~clk;

// Run limit, long enough for the slowest wake with stalls on every command
always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
        $display("Timeout after %0d cycles with %0d responses outstanding", cycles, exp_q.size());
        $display("Done: errors found");
        $finish;
    end
end

// --------------------
// Response monitor

// rsp_valid and rsp are flop outputs, so they are steady at the falling edge
initial begin
    rf_cmd_pkg::rf_rsp_t exp_rsp;
    bit                  cmp;
    rsp_ready = 1'b1;
    forever begin
        @(negedge clk);
        rsp_ready = stall_en ? ($urandom_range(3) != 0) : 1'b1;
        // A transfer takes place at the coming rising edge
        if (rsp_valid && rsp_ready) begin
            rsp_count++;
            if (exp_q.size() == 0) begin
                $display("Response arrived with no command outstanding");
                err_count++;
            end else begin
                exp_rsp = exp_q.pop_front();
                cmp     = cmp_q.pop_front();
                check_op(rsp.op, exp_rsp.op);
                check_status(rsp.status, exp_rsp.status);
                if (cmp) check_rdata(rsp.rdata, exp_rsp.rdata);
            end
        end
    end
end

// --------------------
// Command builders and driver

function automatic rf_cmd_pkg::rf_cmd_t write_cmd(input rf_geom_pkg::rf_addr_t a,
                                                  input rf_geom_pkg::rf_word_t d);
    rf_cmd_pkg::rf_cmd_t c;
    c              = '0;
    c.op           = rf_cmd_pkg::OP_WRITE;
    c.addr         = a;
    c.operand.data = d;
    return c;
endfunction

function automatic rf_cmd_pkg::rf_cmd_t read_cmd(input rf_geom_pkg::rf_addr_t a);
    rf_cmd_pkg::rf_cmd_t c;
    c      = '0;
    c.op   = rf_cmd_pkg::OP_READ;
    c.addr = a;
    return c;
endfunction

function automatic rf_cmd_pkg::rf_cmd_t power_cmd(input rf_cmd_pkg::rf_op_e op,
                                                  input logic [3:0] settle);
    rf_cmd_pkg::rf_cmd_t c;
    c                               = '0;
    c.op                            = op;
    c.operand.pwr.settle_cycles     = settle;
    return c;
endfunction

// Holds the command until cmd_ready is seen, ready settles 1 ns after the falling edge
task automatic issue(input rf_cmd_pkg::rf_cmd_t c);
    bit                  accepted;
    bit                  cmp;
    rf_cmd_pkg::rf_rsp_t exp_rsp;
    accepted = 1'b0;
    @(negedge clk);
    cmd_valid = 1'b1;
    cmd       = c;
    while (!accepted) begin
        #1;
        if (cmd_ready) accepted = 1'b1;
        else @(negedge clk);
    end
    exp_rsp = ref_response(c, cmp);
    exp_q.push_back(exp_rsp);
    cmp_q.push_back(cmp);
    cmd_count++;
    @(posedge clk);
endtask

task automatic open_test();
    test_err0 = err_count;
    test_cmd0 = cmd_count;
endtask

// Waits for every response of the test, then prints its summary line
task automatic drain_and_report(input string name);
    @(negedge clk);
    cmd_valid = 1'b0;
    while (exp_q.size() != 0) @(negedge clk);
    $display("Test %s: %0d commands, %0d errors", name, cmd_count - test_cmd0,
             err_count - test_err0);
endtask

// --------------------
// Tests

task automatic write_then_read();
    rf_geom_pkg::rf_addr_t addrs [16];
    open_test();
    for (int i = 0; i < 16; i++) begin
        addrs[i] = rf_geom_pkg::rf_addr_t'($urandom);
        // The first word sets all 25 bits
        issue(write_cmd(addrs[i], (i == 0) ? '1 : rf_geom_pkg::rf_word_t'($urandom)));
    end
    for (int i = 0; i < 16; i++) issue(read_cmd(addrs[i]));
    drain_and_report("write_then_read");
endtask

task automatic stalled_mix();
    rf_geom_pkg::rf_addr_t a;
    open_test();
    stall_en = 1'b1;
    for (int i = 0; i < 48; i++) begin
        a = rf_geom_pkg::rf_addr_t'($urandom_range(15));
        if ($urandom_range(1) != 0) issue(write_cmd(a, rf_geom_pkg::rf_word_t'($urandom)));
        else issue(read_cmd(a));
    end
    drain_and_report("stalled_mix");
    stall_en = 1'b0;
endtask

task automatic sleep_rejects();
    open_test();
    issue(power_cmd(rf_cmd_pkg::OP_SLEEP, 4'd0));
    for (int i = 0; i < 4; i++) issue(read_cmd(rf_geom_pkg::rf_addr_t'($urandom)));
    for (int i = 0; i < 4; i++) begin
        issue(write_cmd(rf_geom_pkg::rf_addr_t'($urandom), rf_geom_pkg::rf_word_t'($urandom)));
    end
    issue(power_cmd(rf_cmd_pkg::OP_SLEEP, 4'd0));
    drain_and_report("sleep_rejects");
endtask

task automatic wake_and_refill();
    rf_geom_pkg::rf_addr_t addrs [8];
    open_test();
    issue(power_cmd(rf_cmd_pkg::OP_WAKE, 4'($urandom_range(15))));
    issue(power_cmd(rf_cmd_pkg::OP_WAKE, 4'd0));
    for (int i = 0; i < 8; i++) begin
        addrs[i] = rf_geom_pkg::rf_addr_t'($urandom);
        issue(write_cmd(addrs[i], rf_geom_pkg::rf_word_t'($urandom)));
    end
    for (int i = 0; i < 8; i++) issue(read_cmd(addrs[i]));
    drain_and_report("wake_and_refill");
endtask

// Opcodes 4 to 7 are tried awake and asleep
task automatic reserved_ops();
    rf_cmd_pkg::rf_cmd_t c;
    open_test();
    for (int p = 0; p < 2; p++) begin
        for (int i = 0; i < 4; i++) begin
            c      = read_cmd(rf_geom_pkg::rf_addr_t'($urandom));
            c.op   = rf_cmd_pkg::rf_op_e'(3'(4 + i));
            issue(c);
        end
        issue(power_cmd((p == 0) ? rf_cmd_pkg::OP_SLEEP : rf_cmd_pkg::OP_WAKE, 4'd3));
    end
    drain_and_report("reserved_ops");
endtask

initial begin
    void'($urandom(33758));
    clk       = 1'b0;
    arst_n    = 1'b0;
    cmd_valid = 1'b0;
    cmd       = '0;
    stall_en  = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    repeat (2) @(negedge clk);
    write_then_read();
    stalled_mix();
    sleep_rejects();
    wake_and_refill();
    reserved_ops();
    if (rsp_count != cmd_count) begin
        $display("Response count %0d does not match command count %0d", rsp_count, cmd_count);
        err_count++;
    end
    $display("Tests: 5, commands: %0d, responses: %0d, errors: %0d", cmd_count, rsp_count,
             err_count);
    if (err_count == 0) begin
        $display("Done: no errors");
    end else begin
        $display("Done: errors found");
    end
    $finish;
end

endmodule

//--- verilog/rf_array_model.sv
// --------------------
// Behavioural two-port array
// Stands in for the 256x26 vendor macro, loses its contents while powered down
// --------------------

`timescale 1ns/100ps

module rf_array_model (
     input  logic                                wclk
    ,input  logic                                we
    ,input  rf_geom_pkg::rf_addr_t               waddr
    ,input  logic [rf_geom_pkg::RF_MACRO_W-1:0]  wdata

    ,input  logic                                rclk
    ,input  logic                                re
    ,input  rf_geom_pkg::rf_addr_t               raddr
    ,output logic [rf_geom_pkg::RF_MACRO_W-1:0]  data_out

    ,input  logic                                ip_reset_b
    ,input  logic                                isolation_control_in
    ,input  logic                                pwr_mgmt_in
    ,output logic                                pwr_mgmt_out
);

logic [rf_geom_pkg::RF_MACRO_W-1:0] mem [rf_geom_pkg::RF_DEPTH];
logic [rf_geom_pkg::RF_MACRO_W-1:0] rd_q;
logic [rf_geom_pkg::PG_ACK_CYCLES-1:0] pg_dly;

// Power enable echo, one stage per cycle of switch delay
always_ff @(posedge rclk or negedge ip_reset_b) begin
    if (!ip_reset_b) begin
        pg_dly <= '0;
    end else begin
        pg_dly <= {pg_dly[rf_geom_pkg::PG_ACK_CYCLES-2:0], pwr_mgmt_in};
    end
end

// The echo going high means the supply is really off
assign pwr_mgmt_out = pg_dly[rf_geom_pkg::PG_ACK_CYCLES-1];

// While the supply is off every entry decays to unknown
always_ff @(posedge wclk) begin
    if (pwr_mgmt_out) begin
        for (int i = 0; i < rf_geom_pkg::RF_DEPTH; i++) begin
            mem[i] <= 'x;
        end
    end else if (we) begin
        mem[waddr] <= wdata;
    end
end

// Read data is registered and held until the next read
always_ff @(posedge rclk or negedge ip_reset_b) begin
    if (!ip_reset_b) begin
        rd_q <= '0;
    end else if (re) begin
        rd_q <= mem[raddr];
    end
end

// Isolation clamps the outputs of the power domain to zero
assign data_out = isolation_control_in ? '0 : rd_q;

endmodule

//--- verilog/rf_cmd_decode.sv
// --------------------
// Command decode stage
// Registers each command, flags reserved opcodes and unpacks the operand
// --------------------

`timescale 1ns/100ps

module rf_cmd_decode (
     input  logic                 clk
    ,input  logic                 arst_n

    ,input  logic                 cmd_valid
    ,output logic                 cmd_ready
    ,input  rf_cmd_pkg::rf_cmd_t  cmd

    ,output logic                 dec_valid
    ,input  logic                 dec_ready
    ,output rf_cmd_pkg::rf_dec_t  dec
);

rf_cmd_pkg::rf_dec_t dec_d;

// The stage takes a new command when empty or when its output leaves now
assign cmd_ready = !dec_valid || dec_ready;

// Operand view depends on the opcode, unused fields stay zero
always_comb begin
    dec_d      = '0;
    dec_d.op   = cmd.op;
    dec_d.addr = cmd.addr;
    case (cmd.op)
        rf_cmd_pkg::OP_WRITE: begin
            dec_d.wdata = cmd.operand.data;
        end
        rf_cmd_pkg::OP_READ: begin
            // Only the address matters for a read
            dec_d.wdata = '0;
        end
        rf_cmd_pkg::OP_SLEEP, rf_cmd_pkg::OP_WAKE: begin
            dec_d.settle_cycles = cmd.operand.pwr.settle_cycles;
        end
        default: begin
            dec_d.bad_op = 1'b1;
        end
    endcase
end

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        dec_valid <= 1'b0;
    end else if (cmd_valid && cmd_ready) begin
        dec_valid <= 1'b1;
    end else if (dec_ready) begin
        dec_valid <= 1'b0;
    end
end

// Payload only moves on a transfer
always_ff @(posedge clk) begin
    if (cmd_valid && cmd_ready) begin
        dec <= dec_d;
    end
end

endmodule

//--- verilog/rf_cmd_execute.sv
// --------------------
// Command execute stage
// Checks commands against the power state, drives the array and sequences sleep and wake
// --------------------

`timescale 1ns/100ps

module rf_cmd_execute (
     input  logic                   clk
    ,input  logic                   arst_n

    ,input  logic                   dec_valid
    ,output logic                   dec_ready
    ,input  rf_cmd_pkg::rf_dec_t    dec

    ,output logic                   exe_valid
    ,input  logic                   exe_ready
    ,output rf_cmd_pkg::rf_rsp_t    exe_rsp

    // Array access
    ,output logic                   we
    ,output rf_geom_pkg::rf_addr_t  waddr
    ,output rf_geom_pkg::rf_word_t  wdata
    ,output logic                   re
    ,output rf_geom_pkg::rf_addr_t  raddr

    // Power control
    ,output logic                   pgcb_isol_en
    ,output logic                   pwr_enable_b_in
    ,input  logic                   pwr_enable_b_out
);

typedef enum logic [2:0] {
    S_IDLE,
    S_SLP_PWR,
    S_SLP_ACK,
    S_WAK_ACK,
    S_WAK_SET
} exe_state_e;

exe_state_e             state;
logic                   asleep;
logic [3:0]             settle_cnt;
rf_cmd_pkg::rf_status_e status;
logic                   acc_ok;
logic                   rd_ok;
logic                   slp_ok;
logic                   take;

// --------------------
// Status of the command at the head of decode

always_comb begin
    status = rf_cmd_pkg::ST_OK;
    if (dec.bad_op) begin
        status = rf_cmd_pkg::ST_BAD_OP;
    end else begin
        case (dec.op)
            rf_cmd_pkg::OP_SLEEP: if (asleep) status = rf_cmd_pkg::ST_BAD_STATE;
            rf_cmd_pkg::OP_WAKE:  if (!asleep) status = rf_cmd_pkg::ST_BAD_STATE;
            default:              if (asleep) status = rf_cmd_pkg::ST_ASLEEP;
        endcase
    end
end

// A read or write that will reach the array
assign acc_ok = (status == rf_cmd_pkg::ST_OK) &&
                (dec.op == rf_cmd_pkg::OP_READ || dec.op == rf_cmd_pkg::OP_WRITE);
assign rd_ok  = acc_ok && (dec.op == rf_cmd_pkg::OP_READ);

// A sleep that will start the power-down sequence
assign slp_ok = (status == rf_cmd_pkg::ST_OK) && (dec.op == rf_cmd_pkg::OP_SLEEP);

// A read waits for a free result stage so its data cannot be missed
// A sleep waits until execute is empty so that isolation cannot clamp a read still in flight
assign dec_ready = (state == S_IDLE) &&
                   (slp_ok ? !exe_valid : (exe_ready || (!exe_valid && !rd_ok)));
assign take      = dec_valid && dec_ready;

// --------------------
// Control state and power sequencing

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        state           <= S_IDLE;
        asleep          <= 1'b0;
        exe_valid       <= 1'b0;
        we              <= 1'b0;
        re              <= 1'b0;
        pgcb_isol_en    <= 1'b0;
        pwr_enable_b_in <= 1'b0;
    end else begin
        we <= 1'b0;
        re <= 1'b0;
        if (exe_valid && exe_ready) begin
            exe_valid <= 1'b0;
        end
        case (state)
            S_IDLE: begin
                if (take) begin
                    we <= acc_ok && (dec.op == rf_cmd_pkg::OP_WRITE);
                    re <= rd_ok;
                    if (slp_ok) begin
                        // Isolate first, power goes off a cycle later
                        pgcb_isol_en <= 1'b1;
                        state        <= S_SLP_PWR;
                    end else if (status == rf_cmd_pkg::ST_OK &&
                                 dec.op == rf_cmd_pkg::OP_WAKE) begin
                        pwr_enable_b_in <= 1'b0;
                        state           <= S_WAK_ACK;
                    end else begin
                        exe_valid <= 1'b1;
                    end
                end
            end
            S_SLP_PWR: begin
                pwr_enable_b_in <= 1'b1;
                state           <= S_SLP_ACK;
            end
            S_SLP_ACK: begin
                if (pwr_enable_b_out) begin
                    asleep    <= 1'b1;
                    exe_valid <= 1'b1;
                    state     <= S_IDLE;
                end
            end
            S_WAK_ACK: begin
                if (!pwr_enable_b_out) state <= S_WAK_SET;
            end
            default: begin
                // Supply is back, hold isolation until the settle count runs out
                if (settle_cnt == '0) begin
                    pgcb_isol_en <= 1'b0;
                    asleep       <= 1'b0;
                    exe_valid    <= 1'b1;
                    state        <= S_IDLE;
                end
            end
        endcase
    end
end

// Payload registers, loaded when a command is taken
always_ff @(posedge clk) begin
    if (take) begin
        exe_rsp.op     <= dec.op;
        exe_rsp.status <= status;
        // The response never carries data from this stage
        exe_rsp.rdata  <= '0;
        waddr          <= dec.addr;
        wdata          <= dec.wdata;
        raddr          <= dec.addr;
        settle_cnt     <= dec.settle_cycles;
    end else if (state == S_WAK_SET && settle_cnt != '0) begin
        settle_cnt <= settle_cnt - 4'd1;
    end
end

endmodule

//--- verilog/rf_cmd_pkg.sv
// --------------------
// Command and response types
// Opcodes, status codes, the operand union and the structs between pipeline stages
// --------------------

package rf_cmd_pkg;

    // Opcodes 4 to 7 are reserved and rejected by decode
    typedef enum logic [2:0] {
        OP_WRITE = 3'd0,
        OP_READ  = 3'd1,
        OP_SLEEP = 3'd2,
        OP_WAKE  = 3'd3
    } rf_op_e;

    typedef enum logic [1:0] {
        ST_OK        = 2'd0,
        ST_BAD_OP    = 2'd1,
        ST_ASLEEP    = 2'd2,
        ST_BAD_STATE = 2'd3
    } rf_status_e;

    // Power view of the operand, only the low nibble has a meaning
    typedef struct packed {
        logic [rf_geom_pkg::RF_DATA_W-5:0] rsvd;
        logic [3:0]                        settle_cycles;
    } rf_pwr_fields_t;

    // Write data for a write, power fields for sleep and wake
    typedef union packed {
        rf_geom_pkg::rf_word_t data;
        rf_pwr_fields_t        pwr;
    } rf_operand_u;

    typedef struct packed {
        rf_op_e                op;
        rf_geom_pkg::rf_addr_t addr;
        rf_operand_u           operand;
    } rf_cmd_t;

    typedef struct packed {
        rf_op_e                op;
        logic                  bad_op;
        rf_geom_pkg::rf_addr_t addr;
        rf_geom_pkg::rf_word_t wdata;
        logic [3:0]            settle_cycles;
    } rf_dec_t;

    typedef struct packed {
        rf_op_e                op;
        rf_status_e            status;
        rf_geom_pkg::rf_word_t rdata;
    } rf_rsp_t;

endpackage

//--- verilog/rf_geom_pkg.sv
// --------------------
// Register file geometry
// Size of the 256x25 array, the padded macro word and the power-enable echo delay
// --------------------

package rf_geom_pkg;

    // Number of entries in the array
    localparam int RF_DEPTH = 256;

    // Address width that covers every entry
    localparam int RF_ADDR_W = 8;

    // User word as seen by the requester
    localparam int RF_DATA_W = 25;

    // The macro word is one bit wider, the top bit is a pad written as zero
    localparam int RF_MACRO_W = 26;

    // Cycles the array takes to echo a change of power enable
    localparam int PG_ACK_CYCLES = 4;

    typedef logic [RF_ADDR_W-1:0] rf_addr_t;
    typedef logic [RF_DATA_W-1:0] rf_word_t;

endpackage

//--- verilog/rf_pg_256x25.sv
// --------------------
// Power-gated 256x25 register file
// Synchronizes the array reset and adapts the 25-bit word to the 26-bit macro
// --------------------

`timescale 1ns/100ps

module rf_pg_256x25 (
     input  logic                   wclk
    ,input  logic                   we
    ,input  rf_geom_pkg::rf_addr_t  waddr
    ,input  rf_geom_pkg::rf_word_t  wdata

    ,input  logic                   rclk
    ,input  logic                   re
    ,input  rf_geom_pkg::rf_addr_t  raddr
    ,output rf_geom_pkg::rf_word_t  rdata

    ,input  logic                   arst_n

    // Power interface
    ,input  logic                   pgcb_isol_en
    ,input  logic                   pwr_enable_b_in
    ,output logic                   pwr_enable_b_out
);

logic [1:0]                         rst_sync;
logic                               ip_reset_b;
logic [rf_geom_pkg::RF_MACRO_W-1:0] rdata_macro;

// Two-flop synchronizer, asserts at once and releases on rclk
always_ff @(posedge rclk or negedge arst_n) begin
    if (!arst_n) begin
        rst_sync <= 2'b00;
    end else begin
        rst_sync <= {rst_sync[0], 1'b1};
    end
end

assign ip_reset_b = rst_sync[1];

// --------------------
// Array macro

rf_array_model i_rf (
     .wclk                  (wclk)
    ,.we                    (we)
    ,.waddr                 (waddr)
    ,.wdata                 ({1'b0, wdata})
    ,.rclk                  (rclk)
    ,.re                    (re)
    ,.raddr                 (raddr)
    ,.data_out              (rdata_macro)
    ,.ip_reset_b            (ip_reset_b)
    ,.isolation_control_in  (pgcb_isol_en)
    ,.pwr_mgmt_in           (pwr_enable_b_in)
    ,.pwr_mgmt_out          (pwr_enable_b_out)
);

// The pad bit is dropped on the way out
assign rdata = rdata_macro[rf_geom_pkg::RF_DATA_W-1:0];

endmodule

//--- verilog/rf_pg_ctrl_top.sv
// --------------------
// Power-gated register file controller
// Decode, execute and result stages in front of the 256x25 array
// --------------------

`timescale 1ns/100ps

module rf_pg_ctrl_top (
     input  logic                 clk
    ,input  logic                 arst_n

    ,input  logic                 cmd_valid
    ,output logic                 cmd_ready
    ,input  rf_cmd_pkg::rf_cmd_t  cmd

    ,output logic                 rsp_valid
    ,input  logic                 rsp_ready
    ,output rf_cmd_pkg::rf_rsp_t  rsp
);

logic                  dec_valid;
logic                  dec_ready;
rf_cmd_pkg::rf_dec_t   dec;

logic                  exe_valid;
logic                  exe_ready;
rf_cmd_pkg::rf_rsp_t   exe_rsp;

logic                  we;
logic                  re;
rf_geom_pkg::rf_addr_t waddr;
rf_geom_pkg::rf_addr_t raddr;
rf_geom_pkg::rf_word_t wdata;
rf_geom_pkg::rf_word_t rdata;

logic                  pgcb_isol_en;
logic                  pwr_enable_b_in;
logic                  pwr_enable_b_out;

// --------------------
// Pipeline stages

rf_cmd_decode i_decode (
     .clk               (clk)
    ,.arst_n            (arst_n)
    ,.cmd_valid         (cmd_valid)
    ,.cmd_ready         (cmd_ready)
    ,.cmd               (cmd)
    ,.dec_valid         (dec_valid)
    ,.dec_ready         (dec_ready)
    ,.dec               (dec)
);

rf_cmd_execute i_execute (
     .clk               (clk)
    ,.arst_n            (arst_n)
    ,.dec_valid         (dec_valid)
    ,.dec_ready         (dec_ready)
    ,.dec               (dec)
    ,.exe_valid         (exe_valid)
    ,.exe_ready         (exe_ready)
    ,.exe_rsp           (exe_rsp)
    ,.we                (we)
    ,.waddr             (waddr)
    ,.wdata             (wdata)
    ,.re                (re)
    ,.raddr             (raddr)
    ,.pgcb_isol_en      (pgcb_isol_en)
    ,.pwr_enable_b_in   (pwr_enable_b_in)
    ,.pwr_enable_b_out  (pwr_enable_b_out)
);

rf_rsp_result i_result (
     .clk               (clk)
    ,.arst_n            (arst_n)
    ,.exe_valid         (exe_valid)
    ,.exe_ready         (exe_ready)
    ,.exe_rsp           (exe_rsp)
    ,.rdata             (rdata)
    ,.rsp_valid         (rsp_valid)
    ,.rsp_ready         (rsp_ready)
    ,.rsp               (rsp)
);

// --------------------
// Storage, both ports run on the one clock

rf_pg_256x25 i_rf (
     .wclk              (clk)
    ,.we                (we)
    ,.waddr             (waddr)
    ,.wdata             (wdata)
    ,.rclk              (clk)
    ,.re                (re)
    ,.raddr             (raddr)
    ,.rdata             (rdata)
    ,.arst_n            (arst_n)
    ,.pgcb_isol_en      (pgcb_isol_en)
    ,.pwr_enable_b_in   (pwr_enable_b_in)
    ,.pwr_enable_b_out  (pwr_enable_b_out)
);

endmodule

//--- verilog/rf_rsp_result.sv
// --------------------
// Response result stage
// Joins read data with the status and holds the response under back-pressure
// --------------------

`timescale 1ns/100ps

module rf_rsp_result (
     input  logic                   clk
    ,input  logic                   arst_n

    ,input  logic                   exe_valid
    ,output logic                   exe_ready
    ,input  rf_cmd_pkg::rf_rsp_t    exe_rsp

    // Array read data, valid the cycle after a read is handed over
    ,input  rf_geom_pkg::rf_word_t  rdata

    ,output logic                   rsp_valid
    ,input  logic                   rsp_ready
    ,output rf_cmd_pkg::rf_rsp_t    rsp
);

logic rd_pend;
logic take;
logic take_rd;

// Busy while waiting for read data or while a response is held
assign exe_ready = !rd_pend && (!rsp_valid || rsp_ready);
assign take      = exe_valid && exe_ready;
assign take_rd   = take && (exe_rsp.op == rf_cmd_pkg::OP_READ) &&
                   (exe_rsp.status == rf_cmd_pkg::ST_OK);

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        rsp_valid <= 1'b0;
        rd_pend   <= 1'b0;
    end else if (take) begin
        // A good read shows up only once its data is in
        rsp_valid <= !take_rd;
        rd_pend   <= take_rd;
    end else if (rd_pend) begin
        rsp_valid <= 1'b1;
        rd_pend   <= 1'b0;
    end else if (rsp_ready) begin
        rsp_valid <= 1'b0;
    end
end

// Failed commands and non-reads answer with zero data
always_ff @(posedge clk) begin
    if (take) begin
        rsp.op     <= exe_rsp.op;
        rsp.status <= exe_rsp.status;
        rsp.rdata  <= '0;
    end else if (rd_pend) begin
        rsp.rdata <= rdata;
    end
end

endmodule
